//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ddr_cfg_decoder -f filelist.f -o tb_sim
	out=$$(./obj_dir/tb_sim); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- design/cfg_bus_capture.sv
`timescale 1ns/1ps

module cfg_bus_capture (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // configuration network
  input  logic [cfg_decoder_pkg::CFG_ID_W-1:0]     cfgid_i,
  input  logic                                     cfgfwd_i,
  input  cfg_decoder_pkg::cfg_word_t               cfgdata_i,
  input  logic                                     cfgreq_i,
  input  logic                                     cfgdone_i,

  // registered word and strobes
  output cfg_decoder_pkg::cfg_word_t               data_o,
  output logic [cfg_decoder_pkg::NUM_CFG_IDS-1:0]  cfg_we_o,
  output logic [1:0]                               req_we_o,
  output logic                                     req_done_o
);
  import cfg_decoder_pkg::*;

  logic                   cfg_beat;
  logic                   req_beat;
  logic [NUM_CFG_IDS-1:0] cfg_we_d;
  logic                   cfgreq_q;

  // a beat only counts with cfgfwd high
  assign cfg_beat = cfgfwd_i && !cfgreq_i;
  assign req_beat = cfgfwd_i && cfgreq_i;

  // one-hot strobe, ids past the decoded range stay silent
  always_comb begin
    cfg_we_d = '0;
    if (cfg_beat && (cfgid_i < CFG_ID_W'(NUM_CFG_IDS))) begin
      cfg_we_d[cfgid_i[CFG_SEL_W-1:0]] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // word register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cfgfwd_i) begin
      data_o <= cfgdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_we_o   <= '0;
      req_we_o   <= '0;
      cfgreq_q   <= 1'b0;
      req_done_o <= 1'b0;
    end else begin
      cfg_we_o    <= cfg_we_d;
      req_we_o[0] <= req_beat && (cfgid_i == REQ_ID_HEADER);
      req_we_o[1] <= req_beat && (cfgid_i == REQ_ID_ADDR);
      cfgreq_q    <= cfgreq_i;
      // done closes a request when it follows a cycle with cfgreq high
      req_done_o  <= cfgreq_q && cfgdone_i;
    end
  end

endmodule

//--- design/cfg_decoder_pkg.sv
package cfg_decoder_pkg;

  // ----------------------------------------------------------------------
  // network widths
  // ----------------------------------------------------------------------
  localparam int unsigned CFG_DATA_W  = 32;
  localparam int unsigned CFG_ID_W    = 8;
  localparam int unsigned NUM_CFG_IDS = 16;
  // index width of the configuration strobe vector
  localparam int unsigned CFG_SEL_W   = $clog2(NUM_CFG_IDS);

  // ----------------------------------------------------------------------
  // configuration word ids, cfgreq low
  // ----------------------------------------------------------------------
  localparam int unsigned CFG_ID_MODE        = 0;
  localparam int unsigned CFG_ID_DATA_POS_LO = 1;
  localparam int unsigned CFG_ID_DATA_POS_HI = 2;
  localparam int unsigned CFG_ID_ADDR_POS_LO = 3;
  localparam int unsigned CFG_ID_ADDR_POS_HI = 4;
  localparam int unsigned CFG_ID_START_ADDR  = 5;
  localparam int unsigned CFG_ID_MATRIX_DIM  = 6;
  // ids 7 to 9 carry second-level settings, not decoded here
  localparam int unsigned CFG_ID_CIRCU       = 10;
  localparam int unsigned CFG_ID_COL_BURST   = 11;
  localparam int unsigned CFG_ID_ROW_BURST   = 12;
  localparam int unsigned CFG_ID_2ND_BURST   = 13;
  localparam int unsigned CFG_ID_ACCESS_LEN  = 14;
  localparam int unsigned CFG_ID_COMMIT      = 15;

  // request word ids, cfgreq high
  localparam logic [CFG_ID_W-1:0] REQ_ID_HEADER = 8'd0;
  localparam logic [CFG_ID_W-1:0] REQ_ID_ADDR   = 8'd1;

  // ----------------------------------------------------------------------
  // field widths
  // ----------------------------------------------------------------------
  localparam int unsigned NUM_POS      = 8;
  localparam int unsigned POS_W        = 8;
  localparam int unsigned ROW_W        = 16;
  localparam int unsigned COL_W        = 14;
  localparam int unsigned LONG_W       = 30;
  localparam int unsigned CMD_ADDR_W   = 20;
  // set in an address word when it carries a command
  localparam int unsigned CMD_FLAG_BIT = 31;

  // ----------------------------------------------------------------------
  // field types
  // ----------------------------------------------------------------------
  typedef logic [CFG_DATA_W-1:0] cfg_word_t;
  typedef logic [POS_W-1:0]      pos_t;

  // lane k sits in byte k mod 4 of the low or high position word
  typedef pos_t [NUM_POS-1:0]    pos_table_t;

  typedef logic [ROW_W-1:0]      row_t;
  typedef logic [COL_W-1:0]      col_t;

  // address and count fields, bits 29:0 of their word
  typedef logic [LONG_W-1:0]     long_t;

endpackage

//--- design/cfg_register_bank.sv
`timescale 1ns/1ps

module cfg_register_bank (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [cfg_decoder_pkg::NUM_CFG_IDS-1:0]  cfg_we_i,
  input  cfg_decoder_pkg::cfg_word_t               data_i,

  output logic                                     cfg_valid_o,

  // mode word
  output logic                                     cfg_third_req_o,
  output logic                                     cfg_stream_o,
  output logic                                     cfg_broadcast_o,
  output logic                                     cfg_row_column_o,
  output logic                                     cfg_read_write_o,
  output logic                                     cfg_d2d_flag_o,
  output logic [2:0]                               cfg_ch_cluster_num_o,
  output logic [8:0]                               cfg_vr_id_o,
  output logic [2:0]                               cfg_vr_fr_o,
  output logic [4:0]                               cfg_ddr_channel_id_o,

  // position tables
  output cfg_decoder_pkg::pos_table_t              cfg_data_pos_o,
  output cfg_decoder_pkg::pos_table_t              cfg_addr_pos_o,

  output cfg_decoder_pkg::long_t                   cfg_start_addr_o,
  output cfg_decoder_pkg::row_t                    cfg_row_num_o,
  output cfg_decoder_pkg::col_t                    cfg_column_num_o,
  output cfg_decoder_pkg::long_t                   cfg_circu_times_o,

  // burst counts
  output cfg_decoder_pkg::long_t                   cfg_col_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_row_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_2nd_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_access_length_burst_o
);
  import cfg_decoder_pkg::*;

  localparam int unsigned HALF = NUM_POS / 2;

  // ----------------------------------------------------------------------
  // mode word, id 0
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_ddr_channel_id_o <= '0;
      cfg_vr_fr_o          <= '0;
      cfg_vr_id_o          <= '0;
      cfg_ch_cluster_num_o <= '0;
      cfg_d2d_flag_o       <= 1'b0;
      cfg_read_write_o     <= 1'b0;
      cfg_row_column_o     <= 1'b0;
      cfg_broadcast_o      <= 1'b0;
      cfg_stream_o         <= 1'b0;
      cfg_third_req_o      <= 1'b0;
    end else if (cfg_we_i[CFG_ID_MODE]) begin
      cfg_ddr_channel_id_o <= data_i[4:0];
      cfg_vr_fr_o          <= data_i[7:5];
      cfg_vr_id_o          <= data_i[16:8];
      cfg_ch_cluster_num_o <= data_i[22:20];
      cfg_d2d_flag_o       <= data_i[26];
      cfg_read_write_o     <= data_i[27];
      cfg_row_column_o     <= data_i[28];
      cfg_broadcast_o      <= data_i[29];
      cfg_stream_o         <= data_i[30];
      cfg_third_req_o      <= data_i[31];
    end
  end

  // ----------------------------------------------------------------------
  // position tables, ids 1 to 4
  // ----------------------------------------------------------------------
  // each word fills half a table, byte k into lane k
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_data_pos_o <= '0;
      cfg_addr_pos_o <= '0;
    end else begin
      if (cfg_we_i[CFG_ID_DATA_POS_LO]) cfg_data_pos_o[HALF-1:0]       <= data_i;
      if (cfg_we_i[CFG_ID_DATA_POS_HI]) cfg_data_pos_o[NUM_POS-1:HALF] <= data_i;
      if (cfg_we_i[CFG_ID_ADDR_POS_LO]) cfg_addr_pos_o[HALF-1:0]       <= data_i;
      if (cfg_we_i[CFG_ID_ADDR_POS_HI]) cfg_addr_pos_o[NUM_POS-1:HALF] <= data_i;
    end
  end

  // ----------------------------------------------------------------------
  // addresses and counts
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_start_addr_o          <= '0;
      cfg_row_num_o             <= '0;
      cfg_column_num_o          <= '0;
      cfg_circu_times_o         <= '0;
      cfg_col_addr_burst_o      <= '0;
      cfg_row_addr_burst_o      <= '0;
      cfg_2nd_addr_burst_o      <= '0;
      cfg_access_length_burst_o <= '0;
    end else begin
      if (cfg_we_i[CFG_ID_START_ADDR]) cfg_start_addr_o <= data_i[LONG_W-1:0];
      if (cfg_we_i[CFG_ID_MATRIX_DIM]) begin
        cfg_row_num_o    <= data_i[ROW_W-1:0];
        cfg_column_num_o <= data_i[ROW_W +: COL_W];
      end
      // strobes 7 to 9 fall through here
      if (cfg_we_i[CFG_ID_CIRCU])      cfg_circu_times_o    <= data_i[LONG_W-1:0];
      if (cfg_we_i[CFG_ID_COL_BURST])  cfg_col_addr_burst_o <= data_i[LONG_W-1:0];
      if (cfg_we_i[CFG_ID_ROW_BURST])  cfg_row_addr_burst_o <= data_i[LONG_W-1:0];
      if (cfg_we_i[CFG_ID_2ND_BURST])  cfg_2nd_addr_burst_o <= data_i[LONG_W-1:0];
      if (cfg_we_i[CFG_ID_ACCESS_LEN]) begin
        cfg_access_length_burst_o <= data_i[LONG_W-1:0];
      end
    end
  end

  // commit, one-cycle pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_valid_o <= 1'b0;
    end else begin
      cfg_valid_o <= cfg_we_i[CFG_ID_COMMIT];
    end
  end

endmodule

//--- design/ddr_cfg_decoder.sv
`timescale 1ns/1ps

module ddr_cfg_decoder (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // configuration network
  input  logic [cfg_decoder_pkg::CFG_ID_W-1:0]     cfgid_i,
  input  logic                                     cfgfwd_i,
  input  cfg_decoder_pkg::cfg_word_t               cfgdata_i,
  input  logic                                     cfgreq_i,
  input  logic                                     cfgdone_i,

  // request info
  output logic                                     request_data_valid_o,
  output logic                                     request_cmd_valid_o,
  output cfg_decoder_pkg::pos_t                    request_pos_1st_o,
  output logic [2:0]                               request_pos_2nd_o,
  output logic [1:0]                               request_src_type_o,
  output cfg_decoder_pkg::row_t                    request_addr_1st_row_o,
  output cfg_decoder_pkg::col_t                    request_addr_1st_col_o,
  output logic                                     request_addr_last_trans_o,
  output logic [cfg_decoder_pkg::CMD_ADDR_W-1:0]   request_cmd_access_addr_o,

  // configuration info
  output logic                                     cfg_valid_o,
  output logic                                     cfg_third_req_o,
  output logic                                     cfg_stream_o,
  output logic                                     cfg_broadcast_o,
  output logic                                     cfg_row_column_o,
  output logic                                     cfg_read_write_o,
  output logic                                     cfg_d2d_flag_o,
  output logic [2:0]                               cfg_ch_cluster_num_o,
  output logic [8:0]                               cfg_vr_id_o,
  output logic [2:0]                               cfg_vr_fr_o,
  output logic [4:0]                               cfg_ddr_channel_id_o,
  output cfg_decoder_pkg::pos_table_t              cfg_data_pos_o,
  output cfg_decoder_pkg::pos_table_t              cfg_addr_pos_o,
  output cfg_decoder_pkg::long_t                   cfg_start_addr_o,
  output cfg_decoder_pkg::row_t                    cfg_row_num_o,
  output cfg_decoder_pkg::col_t                    cfg_column_num_o,
  output cfg_decoder_pkg::long_t                   cfg_circu_times_o,
  output cfg_decoder_pkg::long_t                   cfg_col_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_row_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_2nd_addr_burst_o,
  output cfg_decoder_pkg::long_t                   cfg_access_length_burst_o
);
  import cfg_decoder_pkg::*;

  // capture stage outputs, one cycle after the beat
  cfg_word_t              cap_data;
  logic [NUM_CFG_IDS-1:0] cap_cfg_we;
  logic [1:0]             cap_req_we;
  logic                   cap_req_done;

  cfg_bus_capture u_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfgid_i    (cfgid_i),
    .cfgfwd_i   (cfgfwd_i),
    .cfgdata_i  (cfgdata_i),
    .cfgreq_i   (cfgreq_i),
    .cfgdone_i  (cfgdone_i),
    .data_o     (cap_data),
    .cfg_we_o   (cap_cfg_we),
    .req_we_o   (cap_req_we),
    .req_done_o (cap_req_done)
  );

  request_decoder u_request (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .req_we_i                  (cap_req_we),
    .data_i                    (cap_data),
    .req_done_i                (cap_req_done),
    .request_data_valid_o      (request_data_valid_o),
    .request_cmd_valid_o       (request_cmd_valid_o),
    .request_pos_1st_o         (request_pos_1st_o),
    .request_pos_2nd_o         (request_pos_2nd_o),
    .request_src_type_o        (request_src_type_o),
    .request_addr_1st_row_o    (request_addr_1st_row_o),
    .request_addr_1st_col_o    (request_addr_1st_col_o),
    .request_addr_last_trans_o (request_addr_last_trans_o),
    .request_cmd_access_addr_o (request_cmd_access_addr_o)
  );

  cfg_register_bank u_bank (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .cfg_we_i                  (cap_cfg_we),
    .data_i                    (cap_data),
    .cfg_valid_o               (cfg_valid_o),
    .cfg_third_req_o           (cfg_third_req_o),
    .cfg_stream_o              (cfg_stream_o),
    .cfg_broadcast_o           (cfg_broadcast_o),
    .cfg_row_column_o          (cfg_row_column_o),
    .cfg_read_write_o          (cfg_read_write_o),
    .cfg_d2d_flag_o            (cfg_d2d_flag_o),
    .cfg_ch_cluster_num_o      (cfg_ch_cluster_num_o),
    .cfg_vr_id_o               (cfg_vr_id_o),
    .cfg_vr_fr_o               (cfg_vr_fr_o),
    .cfg_ddr_channel_id_o      (cfg_ddr_channel_id_o),
    .cfg_data_pos_o            (cfg_data_pos_o),
    .cfg_addr_pos_o            (cfg_addr_pos_o),
    .cfg_start_addr_o          (cfg_start_addr_o),
    .cfg_row_num_o             (cfg_row_num_o),
    .cfg_column_num_o          (cfg_column_num_o),
    .cfg_circu_times_o         (cfg_circu_times_o),
    .cfg_col_addr_burst_o      (cfg_col_addr_burst_o),
    .cfg_row_addr_burst_o      (cfg_row_addr_burst_o),
    .cfg_2nd_addr_burst_o      (cfg_2nd_addr_burst_o),
    .cfg_access_length_burst_o (cfg_access_length_burst_o)
  );

endmodule

//--- design/request_decoder.sv
`timescale 1ns/1ps

module request_decoder (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [1:0]                              req_we_i,
  input  cfg_decoder_pkg::cfg_word_t              data_i,
  input  logic                                    req_done_i,

  output logic                                    request_data_valid_o,
  output logic                                    request_cmd_valid_o,
  output cfg_decoder_pkg::pos_t                   request_pos_1st_o,
  output logic [2:0]                              request_pos_2nd_o,
  output logic [1:0]                              request_src_type_o,
  output cfg_decoder_pkg::row_t                   request_addr_1st_row_o,
  output cfg_decoder_pkg::col_t                   request_addr_1st_col_o,
  output logic                                    request_addr_last_trans_o,
  output logic [cfg_decoder_pkg::CMD_ADDR_W-1:0]  request_cmd_access_addr_o
);
  import cfg_decoder_pkg::*;

  logic hdr_we;
  logic addr_we;
  logic is_cmd;
  logic cmd_flag_q;

  assign hdr_we  = req_we_i[0];
  assign addr_we = req_we_i[1];
  assign is_cmd  = data_i[CMD_FLAG_BIT];

  // ----------------------------------------------------------------------
  // request fields
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      request_pos_1st_o         <= '0;
      request_pos_2nd_o         <= '0;
      request_src_type_o        <= '0;
      request_addr_1st_row_o    <= '0;
      request_addr_1st_col_o    <= '0;
      request_addr_last_trans_o <= 1'b0;
      request_cmd_access_addr_o <= '0;
    end else begin
      if (hdr_we) begin
        request_pos_1st_o  <= data_i[8 +: POS_W];
        request_pos_2nd_o  <= data_i[18:16];
        request_src_type_o <= data_i[21:20];
      end
      // address word, data flavour
      if (addr_we && !is_cmd) begin
        request_addr_1st_row_o    <= data_i[ROW_W-1:0];
        request_addr_1st_col_o    <= data_i[ROW_W +: COL_W];
        request_addr_last_trans_o <= data_i[30];
      end
      // address word, command flavour
      if (addr_we && is_cmd) begin
        request_cmd_access_addr_o <= data_i[CMD_ADDR_W-1:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // command flag and valid pulses
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_flag_q <= 1'b0;
    end else if (addr_we && is_cmd) begin
      // a new command word beats the clear
      cmd_flag_q <= 1'b1;
    end else if (request_cmd_valid_o) begin
      cmd_flag_q <= 1'b0;
    end
  end

  // exactly one pulse per done, picked by the flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      request_data_valid_o <= 1'b0;
      request_cmd_valid_o  <= 1'b0;
    end else begin
      request_data_valid_o <= req_done_i && !cmd_flag_q;
      request_cmd_valid_o  <= req_done_i && cmd_flag_q;
    end
  end

endmodule

//--- filelist.f
design/cfg_decoder_pkg.sv
design/cfg_bus_capture.sv
design/request_decoder.sv
design/cfg_register_bank.sv
design/ddr_cfg_decoder.sv
tests/ddr_cfg_decoder_properties.sv
tests/tb_ddr_cfg_decoder.sv

//--- tests/ddr_cfg_decoder_properties.sv
`timescale 1ns/1ps

module ddr_cfg_decoder_properties (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     cfg_valid_i,
  input logic                                     request_data_valid_i,
  input logic                                     request_cmd_valid_i,
  input logic [cfg_decoder_pkg::NUM_CFG_IDS-1:0]  cfg_we_i,
  input logic [1:0]                               req_we_i
);

  // one request ends in one kind of pulse
  assert property (@(posedge clk) disable iff (!rst_n)
    !(request_data_valid_i && request_cmd_valid_i))
    else $error("data and command valid high together");

  // ----------------------------------------------------------------------
  // valids are single-cycle pulses
  // ----------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n) cfg_valid_i |=> !cfg_valid_i)
    else $error("cfg_valid_o held for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n)
    request_data_valid_i |=> !request_data_valid_i)
    else $error("request_data_valid_o held for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n)
    request_cmd_valid_i |=> !request_cmd_valid_i)
    else $error("request_cmd_valid_o held for more than one cycle");

  // capture strobes
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cfg_we_i))
    else $error("more than one configuration strobe");
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(req_we_i))
    else $error("more than one request strobe");

  assert property (@(posedge clk)
    !rst_n |=> !(cfg_valid_i || request_data_valid_i || request_cmd_valid_i))
    else $error("valid high during reset");

endmodule

bind ddr_cfg_decoder ddr_cfg_decoder_properties u_properties (
  .clk                  (clk),
  .rst_n                (rst_n),
  .cfg_valid_i          (cfg_valid_o),
  .request_data_valid_i (request_data_valid_o),
  .request_cmd_valid_i  (request_cmd_valid_o),
  .cfg_we_i             (cap_cfg_we),
  .req_we_i             (cap_req_we)
);

//--- tests/tb_ddr_cfg_decoder.sv
`timescale 1ns/1ps

module tb_ddr_cfg_decoder;
  import cfg_decoder_pkg::*;

  localparam int NUM_ROWS       = 26;
  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 50;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------
  logic                  clk;
  logic                  rst_n;
  logic [CFG_ID_W-1:0]   cfgid_i;
  logic                  cfgfwd_i;
  cfg_word_t             cfgdata_i;
  logic                  cfgreq_i;
  logic                  cfgdone_i;

  logic                  request_data_valid_o;
  logic                  request_cmd_valid_o;
  pos_t                  request_pos_1st_o;
  logic [2:0]            request_pos_2nd_o;
  logic [1:0]            request_src_type_o;
  row_t                  request_addr_1st_row_o;
  col_t                  request_addr_1st_col_o;
  logic                  request_addr_last_trans_o;
  logic [CMD_ADDR_W-1:0] request_cmd_access_addr_o;

  logic                  cfg_valid_o;
  logic                  cfg_third_req_o;
  logic                  cfg_stream_o;
  logic                  cfg_broadcast_o;
  logic                  cfg_row_column_o;
  logic                  cfg_read_write_o;
  logic                  cfg_d2d_flag_o;
  logic [2:0]            cfg_ch_cluster_num_o;
  logic [8:0]            cfg_vr_id_o;
  logic [2:0]            cfg_vr_fr_o;
  logic [4:0]            cfg_ddr_channel_id_o;
  pos_table_t            cfg_data_pos_o;
  pos_table_t            cfg_addr_pos_o;
  long_t                 cfg_start_addr_o;
  row_t                  cfg_row_num_o;
  col_t                  cfg_column_num_o;
  long_t                 cfg_circu_times_o;
  long_t                 cfg_col_addr_burst_o;
  long_t                 cfg_row_addr_burst_o;
  long_t                 cfg_2nd_addr_burst_o;
  long_t                 cfg_access_length_burst_o;

  // ----------------------------------------------------------------------
  // beat table
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [2:0] test;
    logic       req;
    logic       fwd;
    logic [7:0] id;
    logic       cmd;
    logic       done;
  } beat_t;

  beat_t beats [NUM_ROWS] = '{
    // test, req, fwd, id, cmd, done
    '{3'd2, 1'b0, 1'b1, 8'd0,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd1,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd2,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd3,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd4,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd5,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd6,  1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd10, 1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd11, 1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd12, 1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd13, 1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd14, 1'b0, 1'b0},
    '{3'd2, 1'b0, 1'b1, 8'd15, 1'b0, 1'b0},
    // dropped ids, an id past 15 and a beat without fwd
    '{3'd3, 1'b0, 1'b1, 8'd7,  1'b0, 1'b0},
    '{3'd3, 1'b0, 1'b1, 8'd8,  1'b0, 1'b0},
    '{3'd3, 1'b0, 1'b1, 8'd9,  1'b0, 1'b0},
    '{3'd3, 1'b0, 1'b1, 8'd20, 1'b0, 1'b0},
    '{3'd3, 1'b0, 1'b0, 8'd0,  1'b0, 1'b0},
    '{3'd3, 1'b0, 1'b1, 8'd15, 1'b0, 1'b0},
    // header, address, done
    '{3'd4, 1'b1, 1'b1, 8'd0,  1'b0, 1'b0},
    '{3'd4, 1'b1, 1'b1, 8'd1,  1'b0, 1'b0},
    '{3'd4, 1'b0, 1'b0, 8'd0,  1'b0, 1'b1},
    '{3'd5, 1'b1, 1'b1, 8'd1,  1'b1, 1'b0},
    '{3'd5, 1'b0, 1'b0, 8'd0,  1'b0, 1'b1},
    '{3'd6, 1'b1, 1'b1, 8'd1,  1'b0, 1'b0},
    '{3'd6, 1'b0, 1'b0, 8'd0,  1'b0, 1'b1}
  };

  string test_names [1:6] = '{"reset", "config words", "ignored words",
                              "data request", "command request", "data after command"};

  // reference model state
  cfg_word_t exp_cfg_word [NUM_CFG_IDS] = '{default: '0};
  cfg_word_t exp_hdr_word  = '0;
  cfg_word_t exp_addr_word = '0;
  cfg_word_t exp_cmd_word  = '0;
  logic      exp_cfg_valid  = 1'b0;
  logic      exp_data_valid = 1'b0;
  logic      exp_cmd_valid  = 1'b0;
  logic      cmd_armed = 1'b0;
  logic      prev_req  = 1'b0;

  int        seed;
  cfg_word_t word;
  int        num_checks   = 0;
  int        num_errors   = 0;
  int        start_errors = 0;
  int        cycle_count  = 0;

  ddr_cfg_decoder dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  task automatic predict(input beat_t b, input cfg_word_t w);
    exp_cfg_valid  = b.fwd && !b.req && (b.id == 8'd15);
    exp_data_valid = 1'b0;
    exp_cmd_valid  = 1'b0;
    // done counts only right after a cycle with cfgreq high
    if (b.done && prev_req) begin
      exp_cmd_valid  = cmd_armed;
      exp_data_valid = !cmd_armed;
      cmd_armed      = 1'b0;
    end
    prev_req = b.req;
    if (b.fwd && !b.req && (b.id < 8'd16)) exp_cfg_word[b.id[3:0]] = w;
    if (b.fwd && b.req && (b.id == 8'd0)) exp_hdr_word = w;
    if (b.fwd && b.req && (b.id == 8'd1)) begin
      if (w[31]) begin
        exp_cmd_word = w;
        cmd_armed    = 1'b1;
      end else begin
        exp_addr_word = w;
      end
    end
  endtask

  task automatic check_outputs();
    cfg_word_t mode;
    mode = exp_cfg_word[0];
    check_value("valids", 64'({cfg_valid_o, request_data_valid_o, request_cmd_valid_o}),
                64'({exp_cfg_valid, exp_data_valid, exp_cmd_valid}));
    check_value("mode fields",
                64'({cfg_third_req_o, cfg_stream_o, cfg_broadcast_o, cfg_row_column_o,
                     cfg_read_write_o, cfg_d2d_flag_o, cfg_ch_cluster_num_o, cfg_vr_id_o,
                     cfg_vr_fr_o, cfg_ddr_channel_id_o}),
                64'({mode[31:26], mode[22:20], mode[16:0]}));
    check_value("data positions", cfg_data_pos_o, {exp_cfg_word[2], exp_cfg_word[1]});
    check_value("addr positions", cfg_addr_pos_o, {exp_cfg_word[4], exp_cfg_word[3]});
    check_value("start and circu", 64'({cfg_start_addr_o, cfg_circu_times_o}),
                64'({exp_cfg_word[5][29:0], exp_cfg_word[10][29:0]}));
    check_value("matrix", 64'({cfg_column_num_o, cfg_row_num_o}),
                64'(exp_cfg_word[6][29:0]));
    check_value("col and row burst", 64'({cfg_col_addr_burst_o, cfg_row_addr_burst_o}),
                64'({exp_cfg_word[11][29:0], exp_cfg_word[12][29:0]}));
    check_value("2nd and length burst",
                64'({cfg_2nd_addr_burst_o, cfg_access_length_burst_o}),
                64'({exp_cfg_word[13][29:0], exp_cfg_word[14][29:0]}));
    check_value("request header",
                64'({request_pos_1st_o, request_pos_2nd_o, request_src_type_o}),
                64'({exp_hdr_word[15:8], exp_hdr_word[18:16], exp_hdr_word[21:20]}));
    check_value("request address",
                64'({request_addr_last_trans_o, request_addr_1st_col_o,
                     request_addr_1st_row_o}),
                64'(exp_addr_word[30:0]));
    check_value("command address", 64'(request_cmd_access_addr_o),
                64'(exp_cmd_word[19:0]));
  endtask

  task automatic report_test(input int num);
    $display("test %0d (%s): %0d errors", num, test_names[num], num_errors - start_errors);
    start_errors = num_errors;
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    seed      = 24;
    rst_n     = 1'b0;
    cfgid_i   = '0;
    cfgfwd_i  = 1'b0;
    cfgdata_i = '0;
    cfgreq_i  = 1'b0;
    cfgdone_i = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_outputs();
    report_test(1);
    for (int i = 0; i < NUM_ROWS; i++) begin
      word = $random(seed);
      // bit 31 picks the flavour of an address word
      if (beats[i].req && (beats[i].id == 8'd1)) word[31] = beats[i].cmd;
      cfgreq_i  = beats[i].req;
      cfgfwd_i  = beats[i].fwd;
      cfgid_i   = beats[i].id;
      cfgdata_i = word;
      cfgdone_i = beats[i].done;
      predict(beats[i], word);
      @(posedge clk);
      #1;
      cfgfwd_i  = 1'b0;
      cfgdone_i = 1'b0;
      // fields and pulses show two cycles after the beat
      @(posedge clk);
      #1;
      check_outputs();
      if ((i == NUM_ROWS - 1) || (beats[i + 1].test != beats[i].test)) begin
        report_test(int'(beats[i].test));
      end
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
